/* hw/sdp_wdma_pkg.sv */
// SDP write-DMA interrupt types
package sdp_wdma_pkg;

  // ========================================================================
  // sizes
  // ========================================================================
  // done-interrupt bits, one per layer pointer value
  localparam int INTR_NUM = 2;

  // perf counter width
  localparam int STALL_CNT_W = 32;

  // pending layer pointers, depth must stay a power of two
  localparam int INTR_QUEUE_DEPTH = 4;
  localparam int INTR_QUEUE_AW = 2;

  // ========================================================================
  // encodings
  // ========================================================================
  // element-wise alu algorithm, matches register field values
  typedef enum logic [1:0] {
    ALU_MAX = 2'd0,
    ALU_MIN = 2'd1,
    ALU_SUM = 2'd2,
    ALU_EQL = 2'd3
  } alu_algo_e;

  // output destination of the sdp
  typedef enum logic {
    DST_MEM = 1'b0,
    DST_PDP = 1'b1
  } out_dst_e;

  // ========================================================================
  // bundles
  // ========================================================================
  // register config, static while a layer runs
  typedef struct packed {
    logic      ew_bypass;
    logic      ew_alu_bypass;
    alu_algo_e ew_alu_algo;
    out_dst_e  output_dst;
    logic      op_en;
    logic      perf_dma_en;
  } sdp_cfg_t;

  // observed dma write port
  typedef struct packed {
    logic req_vld;
    logic req_rdy;
    logic rsp_complete;
  } dma_wr_mon_t;

  // layer pointer, picks the done bit
  typedef logic intr_ptr_t;

  typedef logic [INTR_NUM-1:0] done_intr_t;
  typedef logic [STALL_CNT_W-1:0] stall_cnt_t;

endpackage

/* hw/sdp_wdma_intr_queue.sv */
// Pending interrupt pointer queue
`timescale 1ns/10ps

module sdp_wdma_intr_queue import sdp_wdma_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      push_i,
  input  intr_ptr_t push_ptr_i,
  input  logic      pop_i,
  output intr_ptr_t head_ptr_o
);

  // ========================================================================
  // storage and indices
  // ========================================================================
  // pointer slots
  intr_ptr_t mem_q [INTR_QUEUE_DEPTH];

  logic [INTR_QUEUE_AW-1:0] wr_idx_q;
  logic [INTR_QUEUE_AW-1:0] rd_idx_q;
  // occupancy count with one extra bit to tell full from empty
  logic [INTR_QUEUE_AW:0]   count_q;

  logic full;
  logic empty;

  assign full  = (count_q == (INTR_QUEUE_AW + 1)'(INTR_QUEUE_DEPTH));
  assign empty = (count_q == '0);

  // new entry seen at head one cycle later
  always_ff @(posedge nvdla_core_clk) begin
    if (push_i) begin
      mem_q[wr_idx_q] <= push_ptr_i;
    end
  end

  // indices wrap naturally since depth is 2^aw
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
    end else begin
      if (push_i) begin
        wr_idx_q <= wr_idx_q + INTR_QUEUE_AW'(1);
      end
      if (pop_i) begin
        rd_idx_q <= rd_idx_q + INTR_QUEUE_AW'(1);
      end
    end
  end

  // occupancy tracking
  // push and pop together leave it unchanged
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head read straight from the slot
  assign head_ptr_o = mem_q[rd_idx_q];

  // ========================================================================
  // checks
  // ========================================================================
  // more than four layers in flight would drop a pointer
  a_no_overflow: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    push_i && full |-> pop_i
  ) else $error("intr queue push while full");

  // a write completion needs a layer pointer waiting at the head
  a_no_underflow: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    pop_i |-> !empty
  ) else $error("intr queue pop while empty");

endmodule

/* hw/sdp_wdma_done_intr.sv */
// Layer done interrupt tracker
`timescale 1ns/10ps

module sdp_wdma_done_intr import sdp_wdma_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  sdp_cfg_t   cfg_i,
  input  logic       intr_req_vld_i,
  input  intr_ptr_t  intr_req_ptr_i,
  input  logic       rsp_complete_i,
  output done_intr_t done_intr_o
);

  // ========================================================================
  // mode decode
  // ========================================================================
  logic mode_eql;
  logic mode_pdp;
  logic quiet;

  // eql compare writes nothing to memory
  assign mode_eql = !cfg_i.ew_bypass && !cfg_i.ew_alu_bypass &&
                    (cfg_i.ew_alu_algo == ALU_EQL);
  // pdp destination, data leaves on the pdp path
  assign mode_pdp = (cfg_i.output_dst == DST_PDP);
  // no dma write means no completion to wait for
  assign quiet    = mode_eql || mode_pdp;

  // ========================================================================
  // pending pointers
  // ========================================================================
  logic      queue_push;
  intr_ptr_t head_ptr;

  // only normal-mode layers wait for a completion
  assign queue_push = intr_req_vld_i && !quiet;

  sdp_wdma_intr_queue u_intr_queue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .push_i          (queue_push),
    .push_ptr_i      (intr_req_ptr_i),
    .pop_i           (rsp_complete_i),
    .head_ptr_o      (head_ptr)
  );

  // ========================================================================
  // interrupt sources
  // ========================================================================
  done_intr_t intr_direct;
  done_intr_t intr_wr;

  // decode each source onto its bit
  always_comb begin
    for (int i = 0; i < INTR_NUM; i++) begin
      intr_direct[i] = quiet && intr_req_vld_i && (intr_req_ptr_i == intr_ptr_t'(i));
      intr_wr[i]     = rsp_complete_i && (head_ptr == intr_ptr_t'(i));
    end
  end

  // one-cycle pulse after the triggering edge
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_intr_o <= '0;
    end else begin
      done_intr_o <= intr_direct | intr_wr;
    end
  end

  // direct and completion pulses on one bit in one cycle would merge
  a_no_src_overlap: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (intr_direct & intr_wr) == '0
  ) else $error("direct and write interrupt on the same bit");

endmodule

/* hw/sdp_wdma_stall_cnt.sv */
// DMA write stall counter
`timescale 1ns/10ps

module sdp_wdma_stall_cnt import sdp_wdma_pkg::*; (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        op_en_i,
  input  logic        perf_dma_en_i,
  input  dma_wr_mon_t dma_mon_i,
  input  logic        op_load_i,
  output stall_cnt_t  stall_cnt_o
);

  // ========================================================================
  // stall statistic
  // ========================================================================
  logic       cnt_en;
  logic       cnt_inc;
  logic       cnt_clr;
  stall_cnt_t cnt_q;

  // counting gated by both register bits
  assign cnt_en  = op_en_i && perf_dma_en_i;
  // request offered but not taken
  assign cnt_inc = dma_mon_i.req_vld && !dma_mon_i.req_rdy;
  // new layer starts from zero
  assign cnt_clr = op_load_i;

  // clear before increment
  // wraps at 2^32 without saturating
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_q <= '0;
    end else if (cnt_en) begin
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_inc) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign stall_cnt_o = cnt_q;

endmodule

/* hw/sdp_wdma_intr.sv */
// SDP write-DMA interrupt and stall top
`timescale 1ns/10ps

module sdp_wdma_intr import sdp_wdma_pkg::*; (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  sdp_cfg_t    cfg_i,
  input  logic        intr_req_vld_i,
  input  intr_ptr_t   intr_req_ptr_i,
  input  dma_wr_mon_t dma_mon_i,
  input  logic        op_load_i,
  output done_intr_t  done_intr_o,
  output stall_cnt_t  wdma_stall_o
);

  // ========================================================================
  // layer done interrupts
  // ========================================================================
  // completion from the dma write port drives the queue pop
  sdp_wdma_done_intr u_done_intr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_i           (cfg_i),
    .intr_req_vld_i  (intr_req_vld_i),
    .intr_req_ptr_i  (intr_req_ptr_i),
    .rsp_complete_i  (dma_mon_i.rsp_complete),
    .done_intr_o     (done_intr_o)
  );

  // ========================================================================
  // perf statistic
  // ========================================================================
  // only the enable bits of the config matter here
  sdp_wdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en_i         (cfg_i.op_en),
    .perf_dma_en_i   (cfg_i.perf_dma_en),
    .dma_mon_i       (dma_mon_i),
    .op_load_i       (op_load_i),
    .stall_cnt_o     (wdma_stall_o)
  );

endmodule

/* verification/tb_sdp_wdma_ref.svh */
// Write-DMA interrupt reference model
`ifndef TB_SDP_WDMA_REF_SVH
`define TB_SDP_WDMA_REF_SVH

// normal-mode layer pointers still waiting for their write completion
intr_ptr_t model_q[$];

// eql compare and pdp destination write nothing to memory
function automatic logic ref_quiet(input sdp_cfg_t c);
  logic eql_cmp;
  eql_cmp = (c.ew_bypass == 1'b0) && (c.ew_alu_bypass == 1'b0) &&
            (c.ew_alu_algo == ALU_EQL);
  return eql_cmp || (c.output_dst == DST_PDP);
endfunction

// count after this edge, given the sample at this edge
function automatic stall_cnt_t ref_stall_next(input stall_cnt_t cur, input sdp_cfg_t c,
                                              input dma_wr_mon_t mon, input logic load);
  if (!(c.op_en && c.perf_dma_en)) begin
    return cur;
  end
  // load beats a stall in the same cycle
  if (load) begin
    return '0;
  end
  if (mon.req_vld && !mon.req_rdy) begin
    return cur + stall_cnt_t'(1);
  end
  return cur;
endfunction

// pulses for the cycle after this edge, model queue updated on the way
function automatic done_intr_t ref_intr_next(input sdp_cfg_t c, input logic vld,
                                             input intr_ptr_t ptr, input logic complete);
  done_intr_t v;
  v = '0;
  // oldest layer first
  if (complete && model_q.size() > 0) begin
    v[model_q[0]] = 1'b1;
    void'(model_q.pop_front());
  end
  if (vld && ref_quiet(c)) begin
    v[ptr] = 1'b1;
  end else if (vld) begin
    model_q.push_back(ptr);
  end
  return v;
endfunction

`endif

/* verification/tb_sdp_wdma_intr.sv */
// Write-DMA interrupt testbench
`timescale 1ns/10ps

module tb_sdp_wdma_intr import sdp_wdma_pkg::*; ();

  logic        nvdla_core_clk = 1'b0;
  logic        nvdla_core_rstn = 1'b0;
  sdp_cfg_t    cfg;
  logic        req_vld;
  intr_ptr_t   req_ptr;
  dma_wr_mon_t dma_mon;
  logic        op_load;
  done_intr_t  done_intr;
  stall_cnt_t  wdma_stall;

  // expected dut outputs after the latest edge
  done_intr_t  exp_intr = '0;
  stall_cnt_t  exp_stall = '0;

  integer seed = 52;
  int task_errs = 0;
  int model_errs = 0;
  int cmp_errs = 0;
  int test_err_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  `include "tb_sdp_wdma_ref.svh"

  sdp_wdma_intr sdp_wdma_intr_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_i           (cfg),
    .intr_req_vld_i  (req_vld),
    .intr_req_ptr_i  (req_ptr),
    .dma_mon_i       (dma_mon),
    .op_load_i       (op_load),
    .done_intr_o     (done_intr),
    .wdma_stall_o    (wdma_stall)
  );

  // 40 ns period
  always #20 nvdla_core_clk = ~nvdla_core_clk;

  // ==========================================================================
  // model and compare
  // ==========================================================================
  // inputs are stable at the rising edge and sampled there
  always @(posedge nvdla_core_clk) begin
    if (!nvdla_core_rstn) begin
      exp_intr = '0;
      exp_stall = '0;
      model_q.delete();
    end else begin
      if (dma_mon.rsp_complete && model_q.size() == 0) begin
        $display("completion arrived with no layer pending at %0t", $time);
        model_errs++;
      end
      exp_intr  = ref_intr_next(cfg, req_vld, req_ptr, dma_mon.rsp_complete);
      exp_stall = ref_stall_next(exp_stall, cfg, dma_mon, op_load);
    end
  end

  // outputs settled by the falling edge
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      if (done_intr !== exp_intr) begin
        $display("error: done_intr_o got %h expected %h at %0t", done_intr, exp_intr, $time);
        cmp_errs++;
      end
      if (wdma_stall !== exp_stall) begin
        $display("error: wdma_stall_o got %h expected %h at %0t", wdma_stall, exp_stall, $time);
        cmp_errs++;
      end
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic int total_errors();
    return task_errs + model_errs + cmp_errs;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic sdp_cfg_t build_cfg(input logic byp, input logic alu_byp,
                                         input alu_algo_e algo, input out_dst_e dst);
    sdp_cfg_t c;
    c.ew_bypass     = byp;
    c.ew_alu_bypass = alu_byp;
    c.ew_alu_algo   = algo;
    c.output_dst    = dst;
    c.op_en         = 1'b1;
    c.perf_dma_en   = 1'b1;
    return c;
  endfunction

  // 2 ns past the rising edge
  task automatic step();
    @(posedge nvdla_core_clk);
    #2;
  endtask

  task automatic send_req(input intr_ptr_t ptr);
    req_vld = 1'b1;
    req_ptr = ptr;
    step();
    req_vld = 1'b0;
  endtask

  task automatic complete_one();
    dma_mon.rsp_complete = 1'b1;
    step();
    dma_mon.rsp_complete = 1'b0;
  endtask

  // next pulse must land on the bit of ptr alone
  task automatic wait_pulse(input intr_ptr_t ptr);
    int cycles;
    done_intr_t want;
    cycles = 0;
    want = '0;
    want[ptr] = 1'b1;
    while (done_intr === '0 && cycles < 8) begin
      @(negedge nvdla_core_clk);
      cycles++;
    end
    if (done_intr === '0) begin
      $display("timeout: no done interrupt for pointer %0d", ptr);
      task_errs++;
    end else if (done_intr !== want) begin
      $display("error: done_intr_o got %h expected %h", done_intr, want);
      task_errs++;
    end
  endtask

  task automatic random_traffic(input int n);
    repeat (n) begin
      dma_mon.req_vld = 1'(rand_below(2));
      dma_mon.req_rdy = 1'(rand_below(2));
      step();
    end
    dma_mon.req_vld = 1'b0;
    dma_mon.req_rdy = 1'b0;
  endtask

  task automatic end_test(input string name);
    if (total_errors() == test_err_start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, total_errors() - test_err_start);
    end
    test_err_start = total_errors();
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================
  task automatic test_normal();
    intr_ptr_t sent[$];
    intr_ptr_t ptr;
    int n;
    cfg = build_cfg(1'b1, 1'b1, ALU_SUM, DST_MEM);
    for (int round = 0; round < 4; round++) begin
      n = 1 + rand_below(4);
      for (int i = 0; i < n; i++) begin
        ptr = intr_ptr_t'(rand_below(2));
        sent.push_back(ptr);
        send_req(ptr);
      end
      // completions at random gaps in oldest-first order
      while (sent.size() > 0) begin
        repeat (rand_below(4)) step();
        complete_one();
        wait_pulse(sent.pop_front());
      end
    end
    end_test("normal mode");
  endtask

  task automatic test_quiet(input sdp_cfg_t qcfg, input string name);
    intr_ptr_t ptr;
    cfg = qcfg;
    for (int i = 0; i < 8; i++) begin
      ptr = intr_ptr_t'(rand_below(2));
      send_req(ptr);
      wait_pulse(ptr);
      repeat (rand_below(3)) step();
    end
    repeat (4) step();
    end_test(name);
  endtask

  initial begin
    cfg = build_cfg(1'b1, 1'b1, ALU_SUM, DST_MEM);
    req_vld = 1'b0;
    req_ptr = '0;
    dma_mon = '0;
    op_load = 1'b0;
    repeat (16) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;

    @(negedge nvdla_core_clk);
    if (done_intr !== '0) begin
      $display("error: done_intr_o got %h expected 0 after reset", done_intr);
      task_errs++;
    end
    if (wdma_stall !== '0) begin
      $display("error: wdma_stall_o got %h expected 0 after reset", wdma_stall);
      task_errs++;
    end
    end_test("reset values");

    step();
    test_normal();
    test_quiet(build_cfg(1'b0, 1'b0, ALU_EQL, DST_MEM), "eql quiet mode");
    cfg = build_cfg(1'b1, 1'b1, ALU_SUM, DST_PDP);
    test_quiet(cfg, "pdp quiet mode");
    // back to memory output where this layer waits for its completion
    cfg = build_cfg(1'b1, 1'b1, ALU_MAX, DST_MEM);
    send_req(1'b1);
    repeat (3) step();
    complete_one();
    wait_pulse(1'b1);
    end_test("mode switch");

    // stall statistic followed by a hold with each enable low
    random_traffic(200);
    cfg.perf_dma_en = 1'b0;
    random_traffic(40);
    cfg.perf_dma_en = 1'b1;
    cfg.op_en = 1'b0;
    random_traffic(40);
    cfg.op_en = 1'b1;
    end_test("stall count");

    // op load together with a stall
    dma_mon.req_vld = 1'b1;
    repeat (5) step();
    op_load = 1'b1;
    step();
    op_load = 1'b0;
    if (wdma_stall !== '0) begin
      $display("error: wdma_stall_o got %h expected 0 after op load", wdma_stall);
      task_errs++;
    end
    repeat (5) step();
    cfg.perf_dma_en = 1'b0;
    op_load = 1'b1;
    step();
    op_load = 1'b0;
    dma_mon.req_vld = 1'b0;
    repeat (2) step();
    cfg.perf_dma_en = 1'b1;
    end_test("op load clear");

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // overall run limit
  initial begin
    #2000000;
    $display("timeout: simulation did not reach its end");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* sdp_wdma_intr.f */
+incdir+verification
hw/sdp_wdma_pkg.sv
hw/sdp_wdma_intr_queue.sv
hw/sdp_wdma_done_intr.sv
hw/sdp_wdma_stall_cnt.sv
hw/sdp_wdma_intr.sv
verification/tb_sdp_wdma_intr.sv

/* run_sim.sh */
#!/bin/sh
# build and run the write-DMA interrupt testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_sdp_wdma_intr -Mdir obj_dir -f sdp_wdma_intr.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sdp_wdma_intr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
exit 0
